// ==== rtl/link_pkg.sv ====
// SPI protocol shared by the link and the command registers
// Byte 0 of every transfer is the command on MOSI and the version on MISO
package link_pkg;

	// Sent on MISO as byte 0 of every transfer
	localparam logic [7:0] LOGIC_VERSION = 8'h03;

	// Command codes, carried in byte 0 on MOSI
	localparam logic [7:0] CMD_STATUS = 8'h00;
	localparam logic [7:0] CMD_MOTOR = 8'h01;

	// Reply bytes for an unknown command
	localparam logic [7:0] REPLY_INVALID = 8'hEE;

	// Command byte plus four payload bytes
	localparam int FRAME_BYTES = 5;

	// Byte counter width, saturates at the top
	localparam int BYTE_CNT_W = 4;

	// Payload of a motor frame, byte 1 in the low bits
	// hi byte: bit 0 is speed bit 8, bit 1 is direction
	typedef struct packed {
		logic [7:0] m1_hi;
		logic [7:0] m1_lo;
		logic [7:0] m0_hi;
		logic [7:0] m0_lo;
	} motor_frame_t;

endpackage

// ==== rtl/drive_pkg.sv ====
// Motor drive sizes and types, two brushless motors with Hall sensors
package drive_pkg;

	localparam int NUM_MOTORS = 2;

	// Speed command and PWM carrier share a 9-bit range
	localparam int SPEED_W = 9;
	localparam int CARRIER_W = 9;
	localparam int CARRIER_MAX = 510;

	// Hall group is {a, b, c}
	localparam int HALL_W = 3;

	// Quadrature count width
	localparam int ENC_W = 16;

	// sysclk cycles allowed without a motor frame
	localparam int WATCHDOG_CYCLES = 4096;
	localparam int WDOG_W = $clog2(WATCHDOG_CYCLES) + 1;

	typedef struct packed {
		logic dir;
		logic [SPEED_W-1:0] speed;
	} motor_cmd_t;

	// Half-bridge gate pins of one motor
	typedef struct packed {
		logic a_h;
		logic a_l;
		logic b_h;
		logic b_l;
		logic c_h;
		logic c_l;
	} phase_drive_t;

endpackage

// ==== rtl/spi_link.sv ====
`timescale 1ns/1ps
// SPI mode 0 slave, SCK must stay at or below sysclk/8
// Bytes past the 15th are clocked but not counted
module spi_link (
	input  logic sysclk,
	input  logic rst_n,
	input  logic sck,
	input  logic mosi,
	input  logic ncs,
	input  logic [drive_pkg::NUM_MOTORS-1:0][drive_pkg::ENC_W-1:0] enc_count,
	input  logic [drive_pkg::NUM_MOTORS-1:0] fault,
	input  logic frame_ack,
	output logic miso_data,
	output logic miso_oe,
	output logic frame_req,
	output link_pkg::motor_frame_t frame
);
	import link_pkg::*;
	import drive_pkg::*;

	// Pin synchronizers, _m is the first stage
	logic sck_m, sck_s, sck_d;
	logic mosi_m, mosi_s;
	logic ncs_m, ncs_s, ncs_d;

	logic sck_rise, sck_fall;
	logic ncs_fall, ncs_rise;

	logic [2:0] bit_count;
	logic [BYTE_CNT_W-1:0] byte_count;
	logic [7:0] rx_shift;
	logic [7:0] rx_byte;
	logic [7:0] rx_cmd;
	motor_frame_t rx_buf;
	logic [7:0] tx_shift;
	logic [7:0] tx_next;
	logic [NUM_MOTORS-1:0][ENC_W-1:0] enc_cap;
	logic frame_start;

	assign sck_rise = sck_s & ~sck_d;
	assign sck_fall = ~sck_s & sck_d;
	// Start of transfer
	assign ncs_fall = ~ncs_s & ncs_d;
	// End of transfer, byte_count and rx_cmd still valid here
	assign ncs_rise = ncs_s & ~ncs_d;

	// Full byte on the rising SCK of its last bit
	assign rx_byte = {rx_shift[6:0], mosi_s};

	always_ff @(posedge sysclk or negedge rst_n) begin
		if (!rst_n) begin
			sck_m <= 1'b0;
			sck_s <= 1'b0;
			sck_d <= 1'b0;
			mosi_m <= 1'b0;
			mosi_s <= 1'b0;
			// Deselected until the pin says otherwise
			ncs_m <= 1'b1;
			ncs_s <= 1'b1;
			ncs_d <= 1'b1;
		end else begin
			sck_m <= sck;
			sck_s <= sck_m;
			sck_d <= sck_s;
			mosi_m <= mosi;
			mosi_s <= mosi_m;
			ncs_m <= ncs;
			ncs_s <= ncs_m;
			ncs_d <= ncs_s;
		end
	end

	// Bit and byte counters, command byte, transmit shifter
	always_ff @(posedge sysclk or negedge rst_n) begin
		if (!rst_n) begin
			bit_count <= '0;
			byte_count <= '0;
			rx_cmd <= CMD_STATUS;
			tx_shift <= LOGIC_VERSION;
		end else if (ncs_s) begin
			// Idle, version byte waits for the next transfer
			bit_count <= '0;
			byte_count <= '0;
			rx_cmd <= CMD_STATUS;
			tx_shift <= LOGIC_VERSION;
		end else if (sck_rise) begin
			bit_count <= bit_count + 3'd1;
			if (bit_count == 3'd7) begin
				if (byte_count != '1) begin
					byte_count <= byte_count + 1'b1;
				end
				if (byte_count == '0) begin
					rx_cmd <= rx_byte;
				end
			end
		end else if (sck_fall) begin
			// Falling SCK after bit 7 wraps bit_count, load the next byte
			if (bit_count == 3'd0) begin
				tx_shift <= tx_next;
			end else begin
				tx_shift <= {tx_shift[6:0], 1'b0};
			end
		end
	end

	// Receive shifter, payload buffer, encoder snapshot
	always_ff @(posedge sysclk) begin
		if (sck_rise && !ncs_s) begin
			rx_shift <= rx_byte;
			if (bit_count == 3'd7) begin
				case (byte_count)
					1: rx_buf.m0_lo <= rx_byte;
					2: rx_buf.m0_hi <= rx_byte;
					3: rx_buf.m1_lo <= rx_byte;
					4: rx_buf.m1_hi <= rx_byte;
					default: ;
				endcase
			end
		end
		// All counts taken together so a status read is coherent
		if (ncs_fall) begin
			enc_cap <= enc_count;
		end
	end

	// Reply byte for the position just reached
	always_comb begin
		tx_next = 8'h00;
		case (rx_cmd)
			CMD_STATUS: begin
				case (byte_count)
					1: tx_next = enc_cap[0][7:0];
					2: tx_next = enc_cap[0][15:8];
					3: tx_next = enc_cap[1][7:0];
					4: tx_next = enc_cap[1][15:8];
					5: tx_next = {{(8 - NUM_MOTORS){1'b0}}, fault};
					default: tx_next = 8'h00;
				endcase
			end
			CMD_MOTOR: tx_next = 8'h00;
			default: tx_next = REPLY_INVALID;
		endcase
	end

	// Complete motor frame, only when the previous handshake is closed
	assign frame_start = ncs_rise && (rx_cmd == CMD_MOTOR) && (byte_count == FRAME_BYTES)
		&& !frame_req && !frame_ack;

	always_ff @(posedge sysclk or negedge rst_n) begin
		if (!rst_n) begin
			frame_req <= 1'b0;
		end else if (frame_start) begin
			frame_req <= 1'b1;
		end else if (frame_ack) begin
			frame_req <= 1'b0;
		end
	end

	// Held steady for the whole request
	always_ff @(posedge sysclk) begin
		if (frame_start) begin
			frame <= rx_buf;
		end
	end

	assign miso_data = tx_shift[7];
	// Raw pin so the bus is released at once
	assign miso_oe = ~ncs;

endmodule

// ==== rtl/cmd_regs.sv ====
`timescale 1ns/1ps
// Motor command registers behind a four-phase req/ack from the SPI link
// Commands drop to zero speed after WATCHDOG_CYCLES without a frame
module cmd_regs (
	input  logic sysclk,
	input  logic rst_n,
	input  logic frame_req,
	input  link_pkg::motor_frame_t frame,
	output logic frame_ack,
	output drive_pkg::motor_cmd_t [drive_pkg::NUM_MOTORS-1:0] motor_cmd
);
	import drive_pkg::*;

	logic [WDOG_W-1:0] wdog;
	logic take;

	// Low byte is speed 7..0, high byte holds speed bit 8 and direction
	function automatic motor_cmd_t unpack(input logic [7:0] lo, input logic [7:0] hi);
		motor_cmd_t c;
		c.speed = {hi[0], lo};
		c.dir = hi[1];
		return c;
	endfunction

	// New request, not yet acknowledged
	assign take = frame_req & ~frame_ack;

	always_ff @(posedge sysclk or negedge rst_n) begin
		if (!rst_n) begin
			frame_ack <= 1'b0;
		end else if (take) begin
			frame_ack <= 1'b1;
		end else if (!frame_req) begin
			// Request withdrawn, close the handshake
			frame_ack <= 1'b0;
		end
	end

	// Commands and watchdog
	always_ff @(posedge sysclk or negedge rst_n) begin
		if (!rst_n) begin
			motor_cmd <= '0;
			wdog <= '0;
		end else if (take) begin
			motor_cmd[0] <= unpack(frame.m0_lo, frame.m0_hi);
			motor_cmd[1] <= unpack(frame.m1_lo, frame.m1_hi);
			wdog <= '0;
		end else if (wdog != WATCHDOG_CYCLES) begin
			wdog <= wdog + 1'b1;
		end else begin
			// Timed out, hold everything stopped until a new frame
			motor_cmd <= '0;
		end
	end

endmodule

// ==== rtl/quad_counter.sv ====
`timescale 1ns/1ps
// Quadrature counter, each AB state must last at least 3 sysclk cycles
// A and B should rest at 00 through reset or the first step may be miscounted
module quad_counter (
	input  logic sysclk,
	input  logic rst_n,
	input  logic enc_a,
	input  logic enc_b,
	output logic [drive_pkg::ENC_W-1:0] count
);
	// {a, b} synchronizer, _d is the previous state
	logic [1:0] ab_m, ab_s, ab_d;

	// Gray to binary position, up order is 00 01 11 10
	logic [1:0] pos_now, pos_prev;
	logic [1:0] delta;

	assign pos_now = {ab_s[1], ^ab_s};
	assign pos_prev = {ab_d[1], ^ab_d};
	assign delta = pos_now - pos_prev;

	always_ff @(posedge sysclk or negedge rst_n) begin
		if (!rst_n) begin
			ab_m <= 2'b00;
			ab_s <= 2'b00;
			ab_d <= 2'b00;
			count <= '0;
		end else begin
			ab_m <= {enc_a, enc_b};
			ab_s <= ab_m;
			ab_d <= ab_s;
			case (delta)
				2'd1: count <= count + 1'b1;
				2'd3: count <= count - 1'b1;
				// No change, or a double jump with unknown direction
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== rtl/motor_drive.sv ====
`timescale 1ns/1ps
// Six-step brushless drive, high side gated by the shared PWM carrier
// Low side stays on for the whole step, even at zero speed
module motor_drive (
	input  logic sysclk,
	input  logic rst_n,
	input  logic [drive_pkg::HALL_W-1:0] hall,
	input  logic [drive_pkg::CARRIER_W-1:0] carrier,
	input  drive_pkg::motor_cmd_t cmd,
	output drive_pkg::phase_drive_t phase,
	output logic fault
);
	import drive_pkg::*;

	logic [HALL_W-1:0] hall_m, hall_s;

	// One-hot phase picks, bit 2 is a, bit 1 is b, bit 0 is c
	logic [2:0] pick_hi, pick_lo;
	logic [2:0] drv_hi, drv_lo;
	logic pwm_on;
	logic bad_state;
	phase_drive_t phase_next;

	always_ff @(posedge sysclk or negedge rst_n) begin
		if (!rst_n) begin
			hall_m <= '0;
			hall_s <= '0;
		end else begin
			hall_m <= hall;
			hall_s <= hall_m;
		end
	end

	// Commutation table for dir 0, hall is {a, b, c}
	always_comb begin
		case (hall_s)
			3'b001: begin
				pick_hi = 3'b100;
				pick_lo = 3'b010;
			end
			3'b011: begin
				pick_hi = 3'b100;
				pick_lo = 3'b001;
			end
			3'b010: begin
				pick_hi = 3'b010;
				pick_lo = 3'b001;
			end
			3'b110: begin
				pick_hi = 3'b010;
				pick_lo = 3'b100;
			end
			3'b100: begin
				pick_hi = 3'b001;
				pick_lo = 3'b100;
			end
			3'b101: begin
				pick_hi = 3'b001;
				pick_lo = 3'b010;
			end
			// 000 and 111, all bridges off
			default: begin
				pick_hi = 3'b000;
				pick_lo = 3'b000;
			end
		endcase
	end

	assign bad_state = (hall_s == 3'b000) || (hall_s == 3'b111);

	// Reverse swaps which phase sources and which sinks
	assign drv_hi = cmd.dir ? pick_lo : pick_hi;
	assign drv_lo = cmd.dir ? pick_hi : pick_lo;

	// Full on at speed 511 since the carrier tops out at 510
	assign pwm_on = carrier < cmd.speed;

	always_comb begin
		phase_next.a_h = drv_hi[2] & pwm_on;
		phase_next.a_l = drv_lo[2];
		phase_next.b_h = drv_hi[1] & pwm_on;
		phase_next.b_l = drv_lo[1];
		phase_next.c_h = drv_hi[0] & pwm_on;
		phase_next.c_l = drv_lo[0];
	end

	// Gate pins straight from flops
	always_ff @(posedge sysclk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= '0;
			fault <= 1'b0;
		end else begin
			phase <= phase_next;
			fault <= bad_state;
		end
	end

endmodule

// ==== rtl/drive_top.sv ====
`timescale 1ns/1ps
// Drive FPGA top, two motors and two encoders behind an SPI mode 0 slave
// miso floats whenever ncs is high
module drive_top (
	input  logic sysclk,
	input  logic rst_n,
	input  logic sck,
	input  logic mosi,
	input  logic ncs,
	input  logic [drive_pkg::NUM_MOTORS-1:0][drive_pkg::HALL_W-1:0] hall,
	input  logic [drive_pkg::NUM_MOTORS-1:0] enc_a,
	input  logic [drive_pkg::NUM_MOTORS-1:0] enc_b,
	output wire miso,
	output drive_pkg::phase_drive_t [drive_pkg::NUM_MOTORS-1:0] phase
);
	import link_pkg::*;
	import drive_pkg::*;

	logic miso_data, miso_oe;
	logic frame_req, frame_ack;
	motor_frame_t frame;
	motor_cmd_t [NUM_MOTORS-1:0] motor_cmd;
	logic [NUM_MOTORS-1:0][ENC_W-1:0] enc_count;
	logic [NUM_MOTORS-1:0] fault;

	// Shared triangle carrier, 0 up to CARRIER_MAX and back
	logic [CARRIER_W-1:0] carrier;
	logic carrier_down;

	always_ff @(posedge sysclk or negedge rst_n) begin
		if (!rst_n) begin
			carrier <= '0;
			carrier_down <= 1'b0;
		end else if (!carrier_down) begin
			// Turn at the top
			if (carrier == CARRIER_MAX - 1) begin
				carrier_down <= 1'b1;
			end
			carrier <= carrier + 1'b1;
		end else begin
			if (carrier == 1) begin
				carrier_down <= 1'b0;
			end
			carrier <= carrier - 1'b1;
		end
	end

	spi_link u_link (
		.sysclk    (sysclk),
		.rst_n     (rst_n),
		.sck       (sck),
		.mosi      (mosi),
		.ncs       (ncs),
		.enc_count (enc_count),
		.fault     (fault),
		.frame_ack (frame_ack),
		.miso_data (miso_data),
		.miso_oe   (miso_oe),
		.frame_req (frame_req),
		.frame     (frame)
	);

	cmd_regs u_cmd (
		.sysclk    (sysclk),
		.rst_n     (rst_n),
		.frame_req (frame_req),
		.frame     (frame),
		.frame_ack (frame_ack),
		.motor_cmd (motor_cmd)
	);

	// One encoder and one motor per channel, hall[m] is {a, b, c}
	for (genvar m = 0; m < NUM_MOTORS; m++) begin : g_chan
		quad_counter u_enc (
			.sysclk (sysclk),
			.rst_n  (rst_n),
			.enc_a  (enc_a[m]),
			.enc_b  (enc_b[m]),
			.count  (enc_count[m])
		);

		motor_drive u_motor (
			.sysclk  (sysclk),
			.rst_n   (rst_n),
			.hall    (hall[m]),
			.carrier (carrier),
			.cmd     (motor_cmd[m]),
			.phase   (phase[m]),
			.fault   (fault[m])
		);
	end

	assign miso = miso_oe ? miso_data : 1'bz;

endmodule

// ==== verif/tb_checker.sv ====
`timescale 1ns/1ps
// Watches the DUT pins and compares them with a model of SPI replies, encoders and motor pins
// Samples on falling sysclk, so inputs driven after the rising edge are already stable
module tb_checker (
	input  logic sysclk,
	input  logic rst_n,
	input  logic sck,
	input  logic mosi,
	input  logic ncs,
	input  logic miso,
	input  logic [drive_pkg::NUM_MOTORS-1:0][drive_pkg::HALL_W-1:0] hall,
	input  logic [drive_pkg::NUM_MOTORS-1:0] enc_a,
	input  logic [drive_pkg::NUM_MOTORS-1:0] enc_b,
	input  drive_pkg::phase_drive_t [drive_pkg::NUM_MOTORS-1:0] phase,
	output int error_count,
	output int byte_checks,
	output int pin_checks
);
	import link_pkg::*;
	import drive_pkg::*;

	// Cycles allowed for synchronizers and registers to catch up
	localparam int SETTLE = 10;
	// Pin order a_h a_l b_h b_l c_h c_l
	localparam logic [5:0] HIGH_PINS = 6'b101010;
	localparam logic [5:0] LOW_PINS = 6'b010101;

	logic sck_q, ncs_q;
	logic [1:0] enc_q [NUM_MOTORS];
	logic [15:0] enc_model [NUM_MOTORS];
	logic [15:0] enc_snap [NUM_MOTORS];
	logic [HALL_W-1:0] hall_q [NUM_MOTORS];
	int hall_quiet [NUM_MOTORS];
	logic [SPEED_W-1:0] speed_model [NUM_MOTORS];
	logic dir_model [NUM_MOTORS];
	int since_frame;
	int bit_idx, byte_idx;
	logic [7:0] mosi_sr, miso_sr, cmd_byte;
	logic [7:0] payload [1:4];

	// Position in the up order 00 01 11 10
	function automatic int gray_pos(input logic [1:0] ab);
		case (ab)
			2'b00: return 0;
			2'b01: return 1;
			2'b11: return 2;
			default: return 3;
		endcase
	endfunction

	// Pins of one motor at full speed, zero for an invalid Hall state
	function automatic logic [5:0] table_pins(input logic [2:0] h, input logic rev);
		logic [3:0] pair;
		logic [5:0] pins;
		int src, snk;
		pins = '0;
		// Phase index 0 is a, 1 is b, 2 is c, high phase in the top half
		case (h)
			3'b001: pair = {2'd0, 2'd1};
			3'b011: pair = {2'd0, 2'd2};
			3'b010: pair = {2'd1, 2'd2};
			3'b110: pair = {2'd1, 2'd0};
			3'b100: pair = {2'd2, 2'd0};
			3'b101: pair = {2'd2, 2'd1};
			default: pair = 4'hF;
		endcase
		if (pair != 4'hF) begin
			src = rev ? pair[1:0] : pair[3:2];
			snk = rev ? pair[3:2] : pair[1:0];
			pins[5 - 2 * src] = 1'b1;
			pins[4 - 2 * snk] = 1'b1;
		end
		return pins;
	endfunction

	// Reply byte idx of a transfer that started with cmd
	function automatic logic [7:0] expected_reply(input logic [7:0] cmd, input int idx);
		logic [7:0] flt;
		flt = '0;
		for (int m = 0; m < NUM_MOTORS; m++) begin
			flt[m] = (hall_q[m] == 3'b000) || (hall_q[m] == 3'b111);
		end
		if (idx == 0) return LOGIC_VERSION;
		if (cmd == CMD_MOTOR) return 8'h00;
		if (cmd != CMD_STATUS) return REPLY_INVALID;
		case (idx)
			1: return enc_snap[0][7:0];
			2: return enc_snap[0][15:8];
			3: return enc_snap[1][7:0];
			4: return enc_snap[1][15:8];
			5: return flt;
			default: return 8'h00;
		endcase
	endfunction

	always @(negedge sysclk) begin : watch
		logic [1:0] ab;
		logic [7:0] exp_byte;
		logic [SPEED_W-1:0] spd;
		logic rev;
		logic [5:0] full, must_on, may_on, act;
		if (!rst_n) begin
			sck_q = 1'b0;
			ncs_q = 1'b1;
			since_frame = 0;
			bit_idx = 0;
			byte_idx = 0;
			cmd_byte = 8'h00;
			error_count = 0;
			byte_checks = 0;
			pin_checks = 0;
			for (int m = 0; m < NUM_MOTORS; m++) begin
				enc_q[m] = 2'b00;
				enc_model[m] = '0;
				hall_q[m] = hall[m];
				hall_quiet[m] = 0;
				speed_model[m] = '0;
				dir_model[m] = 1'b0;
			end
		end else begin
			// Encoder model, one count per step in the Gray order
			for (int m = 0; m < NUM_MOTORS; m++) begin
				ab = {enc_a[m], enc_b[m]};
				if (gray_pos(ab) == (gray_pos(enc_q[m]) + 1) % 4) begin
					enc_model[m] = enc_model[m] + 16'd1;
				end else if (gray_pos(enc_q[m]) == (gray_pos(ab) + 1) % 4) begin
					enc_model[m] = enc_model[m] - 16'd1;
				end
				enc_q[m] = ab;
				if (hall[m] != hall_q[m]) begin
					hall_q[m] = hall[m];
					hall_quiet[m] = 0;
				end else if (hall_quiet[m] < SETTLE) begin
					hall_quiet[m]++;
				end
			end
			if (since_frame < WATCHDOG_CYCLES + SETTLE) begin
				since_frame++;
			end

			// Transfer starts, counts frozen here
			if (ncs_q && !ncs) begin
				bit_idx = 0;
				byte_idx = 0;
				cmd_byte = 8'h00;
				enc_snap = enc_model;
			end
			if (!ncs && sck && !sck_q) begin
				mosi_sr = {mosi_sr[6:0], mosi};
				miso_sr = {miso_sr[6:0], miso};
				bit_idx++;
				if (bit_idx == 8) begin
					bit_idx = 0;
					if (byte_idx == 0) begin
						cmd_byte = mosi_sr;
					end else if (byte_idx <= 4) begin
						payload[byte_idx] = mosi_sr;
					end
					exp_byte = expected_reply(cmd_byte, byte_idx);
					byte_checks++;
					if (miso_sr !== exp_byte) begin
						error_count++;
						$display("MISMATCH miso byte %0d (cmd 0x%02h): got 0x%02h, expected 0x%02h",
							byte_idx, cmd_byte, miso_sr, exp_byte);
					end
					byte_idx++;
				end
			end
			// Transfer ends, a complete motor frame loads the command model
			if (!ncs_q && ncs && cmd_byte == CMD_MOTOR && byte_idx == FRAME_BYTES) begin
				speed_model[0] = {payload[2][0], payload[1]};
				dir_model[0] = payload[2][1];
				speed_model[1] = {payload[4][0], payload[3]};
				dir_model[1] = payload[4][1];
				since_frame = 0;
			end
			sck_q = sck;
			ncs_q = ncs;

			// Motor pins, skipped while a Hall change, a frame or the timeout settles
			for (int m = 0; m < NUM_MOTORS; m++) begin
				if (hall_quiet[m] >= SETTLE && since_frame >= SETTLE
						&& !(since_frame >= WATCHDOG_CYCLES
						&& since_frame < WATCHDOG_CYCLES + SETTLE)) begin
					spd = (since_frame < WATCHDOG_CYCLES) ? speed_model[m] : '0;
					rev = (since_frame < WATCHDOG_CYCLES) ? dir_model[m] : 1'b0;
					full = table_pins(hall_q[m], rev);
					// Speed above the carrier top is always on, zero is never on
					must_on = (full & LOW_PINS) | ((spd > CARRIER_MAX) ? (full & HIGH_PINS) : 6'b0);
					may_on = (full & LOW_PINS) | ((spd != 0) ? (full & HIGH_PINS) : 6'b0);
					act = phase[m];
					pin_checks++;
					if ((act & must_on) != must_on || (act & ~may_on) != 6'b0) begin
						error_count++;
						$display("MISMATCH phase[%0d]: got 0x%02h, expected 0x%02h (allowed 0x%02h)",
							m, act, must_on, may_on);
					end
				end
			end
		end
	end

endmodule

// ==== verif/tb_top.sv ====
`timescale 1ns/1ps
// Random SPI traffic against the drive FPGA, seed 54, inputs change 5 ns after rising sysclk
// SCK runs at sysclk/8; encoder steps and Hall changes happen only between transfers
module tb_top;
	import link_pkg::*;
	import drive_pkg::*;

	localparam int NUM_TRANSFERS = 60;
	// One full carrier period plus slack
	localparam int CARRIER_HOLD = 2 * CARRIER_MAX + 80;
	localparam int CYCLE_LIMIT = NUM_TRANSFERS * 60 * 8 * 8 + WATCHDOG_CYCLES + 20000;

	logic sysclk = 1'b0;
	logic rst_n;
	logic sck, mosi, ncs;
	logic [NUM_MOTORS-1:0][HALL_W-1:0] hall;
	logic [NUM_MOTORS-1:0] enc_a, enc_b;
	wire miso;
	phase_drive_t [NUM_MOTORS-1:0] phase;

	int error_count, byte_checks, pin_checks;
	int cycle_count;
	int unsigned seed_ret;
	logic [7:0] tx_buf [0:7];

	always #20 sysclk = ~sysclk;

	drive_top dut_i (
		.sysclk (sysclk),
		.rst_n  (rst_n),
		.sck    (sck),
		.mosi   (mosi),
		.ncs    (ncs),
		.hall   (hall),
		.enc_a  (enc_a),
		.enc_b  (enc_b),
		.miso   (miso),
		.phase  (phase)
	);

	tb_checker chk_i (
		.sysclk      (sysclk),
		.rst_n       (rst_n),
		.sck         (sck),
		.mosi        (mosi),
		.ncs         (ncs),
		.miso        (miso),
		.hall        (hall),
		.enc_a       (enc_a),
		.enc_b       (enc_b),
		.phase       (phase),
		.error_count (error_count),
		.byte_checks (byte_checks),
		.pin_checks  (pin_checks)
	);

	// Step n rising edges, then 5 ns past the last one
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge sysclk);
		#5;
	endtask

	// Mode 0, MSB first, 4 cycles low then 4 high
	task automatic spi_byte(input logic [7:0] tx);
		for (int i = 7; i >= 0; i--) begin
			mosi = tx[i];
			wait_cycles(4);
			sck = 1'b1;
			wait_cycles(4);
			sck = 1'b0;
		end
	endtask

	task automatic spi_transfer(input int n);
		ncs = 1'b0;
		wait_cycles(6);
		for (int b = 0; b < n; b++) begin
			spi_byte(tx_buf[b]);
		end
		wait_cycles(4);
		ncs = 1'b1;
		wait_cycles(12);
	endtask

	// Unused high bits of each hi byte carry junk
	task automatic send_motor(input logic [SPEED_W-1:0] s0, input logic d0,
			input logic [SPEED_W-1:0] s1, input logic d1);
		logic [5:0] pad;
		pad = $urandom;
		tx_buf[0] = CMD_MOTOR;
		tx_buf[1] = s0[7:0];
		tx_buf[2] = {pad, d0, s0[8]};
		tx_buf[3] = s1[7:0];
		tx_buf[4] = {~pad, d1, s1[8]};
		spi_transfer(FRAME_BYTES);
	endtask

	task automatic send_status();
		tx_buf[0] = CMD_STATUS;
		for (int b = 1; b < 8; b++) begin
			tx_buf[b] = $urandom;
		end
		spi_transfer(6 + $urandom % 2);
	endtask

	// Any code other than status and motor
	task automatic send_invalid();
		tx_buf[0] = 8'h02 + ($urandom % 254);
		for (int b = 1; b < 8; b++) begin
			tx_buf[b] = $urandom;
		end
		spi_transfer(2 + $urandom % 3);
	endtask

	function automatic logic [1:0] gray_next(input logic [1:0] ab, input logic up);
		case (ab)
			2'b00: return up ? 2'b01 : 2'b10;
			2'b01: return up ? 2'b11 : 2'b00;
			2'b11: return up ? 2'b10 : 2'b01;
			default: return up ? 2'b00 : 2'b11;
		endcase
	endfunction

	function automatic logic [2:0] valid_hall(input int idx);
		case (idx)
			0: return 3'b001;
			1: return 3'b011;
			2: return 3'b010;
			3: return 3'b110;
			4: return 3'b100;
			default: return 3'b101;
		endcase
	endfunction

	// Zero, full, or anything between
	function automatic logic [SPEED_W-1:0] pick_speed();
		int r;
		r = $urandom % 3;
		if (r == 0) return '0;
		if (r == 1) return 9'd511;
		return 9'd1 + ($urandom % 510);
	endfunction

	task automatic step_encoder(input int m, input logic up);
		logic [1:0] ab;
		ab = gray_next({enc_a[m], enc_b[m]}, up);
		enc_a[m] = ab[1];
		enc_b[m] = ab[0];
		wait_cycles(4 + $urandom % 3);
	endtask

	task automatic stir_inputs();
		int steps;
		int m;
		steps = $urandom % 6;
		for (int i = 0; i < steps; i++) begin
			step_encoder($urandom % NUM_MOTORS, $urandom % 2);
		end
		if ($urandom % 2) begin
			m = $urandom % NUM_MOTORS;
			// Mostly valid, sometimes 000 or 111
			if ($urandom % 5 == 0) begin
				hall[m] = ($urandom % 2) ? 3'b111 : 3'b000;
			end else begin
				hall[m] = valid_hall($urandom % 6);
			end
		end
		// Encoders and Halls settle before ncs falls
		wait_cycles(12);
	endtask

	task automatic report_and_finish();
		int total;
		total = error_count;
		if (byte_checks == 0 || pin_checks == 0) begin
			$display("No MISO bytes or motor pin states were checked");
			total++;
		end
		$display("errors: %0d, miso bytes checked: %0d, pin checks: %0d",
			total, byte_checks, pin_checks);
		if (total == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	endtask

	initial begin
		seed_ret = $urandom(54);
		rst_n = 1'b0;
		sck = 1'b0;
		mosi = 1'b0;
		ncs = 1'b1;
		hall[0] = 3'b001;
		hall[1] = 3'b011;
		enc_a = '0;
		enc_b = '0;
		repeat (4) @(posedge sysclk);
		#5;
		rst_n = 1'b1;
		wait_cycles(10);
		for (int t = 0; t < NUM_TRANSFERS; t++) begin
			stir_inputs();
			case ($urandom % 3)
				0: send_status();
				1: send_motor(pick_speed(), $urandom % 2, pick_speed(), $urandom % 2);
				default: send_invalid();
			endcase
		end
		// Valid Halls for the directed holds
		hall[0] = valid_hall($urandom % 6);
		hall[1] = valid_hall($urandom % 6);
		wait_cycles(12);
		send_motor(9'd511, 1'b0, 9'd511, 1'b1);
		wait_cycles(CARRIER_HOLD);
		send_motor('0, 1'b1, '0, 1'b0);
		wait_cycles(CARRIER_HOLD);
		// Last frame, then silence until the watchdog stops both motors
		send_motor(9'd511, 1'b1, 9'd511, 1'b0);
		wait_cycles(WATCHDOG_CYCLES + 10 + CARRIER_HOLD);
		report_and_finish();
	end

	always @(posedge sysclk) begin
		cycle_count++;
		if (cycle_count == CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d sysclk cycles", CYCLE_LIMIT);
			$display("errors: %0d, miso bytes checked: %0d, pin checks: %0d",
				error_count + 1, byte_checks, pin_checks);
			$display("TEST FAILED");
			$finish;
		end
	end

endmodule

// ==== compile.f ====
rtl/link_pkg.sv
rtl/drive_pkg.sv
rtl/spi_link.sv
rtl/cmd_regs.sv
rtl/quad_counter.sv
rtl/motor_drive.sv
rtl/drive_top.sv
verif/tb_checker.sv
verif/tb_top.sv
